/* Bender.yml */
package:
  name: msg_rx

sources:
  - design/msg_rx_pkg.sv
  - design/msg_cmd_dec.sv
  - design/msg_arg_collect.sv
  - design/msg_byte_timer.sv
  - design/msg_rx_ctrl.sv
  - design/msg_rx.sv
  - target: simulation
    files:
      - dv/msg_rx_assertions.sv
      - dv/msg_rx_tb.sv

/* design/msg_arg_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_arg_collect (
	input  logic                   clk_sys,
	input  logic                   rst,
	input  msg_rx_pkg::msg_byte_t  byte_data,
	input  logic                   load,
	input  msg_rx_pkg::msg_field_t field,
	input  logic                   commit,
	input  msg_rx_pkg::msg_cmd_t   flags_in,
	output msg_rx_pkg::msg_byte_t  cmd_staged,
	output msg_rx_pkg::msg_cmd_t   cmd,
	output msg_rx_pkg::msg_args_t  args
);

	import msg_rx_pkg::*;

	msg_args_t staged;

	////////////////////
	// Staging
	////////////////////

	// Fields not named by the message keep what they held.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cmd_staged <= '0;
			staged     <= '0;
		end else if (load) begin
			case (field)
				FIELD_CMD: begin
					cmd_staged <= byte_data;
					staged     <= args;  // Drops bytes of an abandoned message.
				end
				FIELD_A1:  staged.a1       <= byte_data;
				FIELD_A2H: staged.a2[0:7]  <= byte_data;  // High byte first.
				FIELD_A2L: staged.a2[8:15] <= byte_data;
				FIELD_A3H: staged.a3[0:7]  <= byte_data;
				FIELD_A3L: staged.a3[8:15] <= byte_data;
				default: begin
				end
			endcase
		end
	end

	////////////////////
	// Published outputs
	////////////////////

	// Whole message becomes visible on one edge.
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cmd  <= '0;
			args <= '0;
		end else if (commit) begin
			cmd  <= flags_in;
			args <= staged;
		end
	end

endmodule

`default_nettype wire

/* design/msg_byte_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_byte_timer (
	input  logic clk_sys,
	input  logic rst,
	input  logic run,
	input  logic restart,
	output logic expired
);

	import msg_rx_pkg::*;

	msg_tmr_t count;

	// Counts idle cycles, sticks at all ones.
	always_ff @(posedge clk_sys) begin
		if (rst || restart || !run) begin
			count <= '0;
		end else if (count != '1) begin
			count <= count + 1'b1;
		end
	end

	// Saturation past the limit keeps this to a single cycle.
	assign expired = run && (count == MSG_TIMEOUT);

endmodule

`default_nettype wire

/* design/msg_cmd_dec.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_cmd_dec (
	input  msg_rx_pkg::msg_byte_t cmd_byte,
	output msg_rx_pkg::msg_cmd_t  flags
);

	import msg_rx_pkg::*;

	msg_opcode_t opcode;

	// Mask bits 5 to 7 take no part in the decode.
	assign opcode = cmd_byte[0:4];

	always_comb begin
		flags = '0;
		case (opcode)
			OP_R: begin
				flags.r = 1'b1;
			end
			OP_W: begin
				flags.w = 1'b1;
			end
			OP_IN: begin
				flags.in = 1'b1;
			end
			OP_PA: begin
				flags.pa = 1'b1;
			end
			OP_OK: begin
				flags.ok = 1'b1;
			end
			OP_PE: begin
				flags.pe = 1'b1;
			end
			OP_EN: begin
				flags.en = 1'b1;
			end
			OP_CPD: begin
				flags.cpd = 1'b1;
			end
			OP_CPR: begin
				flags.cpr = 1'b1;
			end
			OP_CPF: begin
				flags.cpf = 1'b1;
			end
			OP_CPS: begin
				flags.cps = 1'b1;
			end
			default: begin
				flags.unknown = 1'b1;  // Opcode 0 and 12 to 31.
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/msg_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_rx (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  msg_rx_pkg::msg_byte_t byte_data,
	input  logic                  byte_valid,
	output msg_rx_pkg::msg_cmd_t  cmd,
	output msg_rx_pkg::msg_args_t args,
	output logic                  ready,
	output logic                  timeout
);

	import msg_rx_pkg::*;

	logic       load;
	msg_field_t field;
	logic       commit;
	logic       run;
	logic       restart;
	logic       expired;
	msg_byte_t  cmd_staged;
	msg_cmd_t   flags;

	////////////////////
	// Control
	////////////////////

	msg_rx_ctrl msg_rx_ctrl_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.byte_valid (byte_valid),
		.arg_mask   (cmd_staged[5:7]),  // Mask bits of the staged command.
		.expired    (expired),
		.load       (load),
		.field      (field),
		.commit     (commit),
		.run        (run),
		.restart    (restart),
		.ready      (ready),
		.timeout    (timeout)
	);

	msg_byte_timer msg_byte_timer_i (
		.clk_sys (clk_sys),
		.rst     (rst),
		.run     (run),
		.restart (restart),
		.expired (expired)
	);

	////////////////////
	// Data path
	////////////////////

	msg_arg_collect msg_arg_collect_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.byte_data  (byte_data),
		.load       (load),
		.field      (field),
		.commit     (commit),
		.flags_in   (flags),
		.cmd_staged (cmd_staged),
		.cmd        (cmd),
		.args       (args)
	);

	msg_cmd_dec msg_cmd_dec_i (
		.cmd_byte (cmd_staged),
		.flags    (flags)
	);

endmodule

`default_nettype wire

/* design/msg_rx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_rx_ctrl (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     byte_valid,
	input  msg_rx_pkg::msg_argmask_t arg_mask,
	input  logic                     expired,
	output logic                     load,
	output msg_rx_pkg::msg_field_t   field,
	output logic                     commit,
	output logic                     run,
	output logic                     restart,
	output logic                     ready,
	output logic                     timeout
);

	import msg_rx_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		ARG,
		A1,
		A2H,
		A2L,
		A3H,
		A3L,
		DONE
	} state_t;

	state_t state;
	state_t state_next;
	logic   waiting;
	logic   accept;

	////////////////////
	// Byte acceptance
	////////////////////

	assign waiting = (state != ARG) && (state != DONE);
	assign run     = waiting && (state != IDLE);  // Argument states only.
	assign accept  = waiting && byte_valid && !expired;
	assign load    = accept;
	assign restart = accept;
	assign commit  = (state == DONE);

	always_comb begin
		case (state)
			A1:      field = FIELD_A1;
			A2H:     field = FIELD_A2H;
			A2L:     field = FIELD_A2L;
			A3H:     field = FIELD_A3H;
			A3L:     field = FIELD_A3L;
			default: field = FIELD_CMD;
		endcase
	end

	////////////////////
	// Sequencing
	////////////////////

	// Absent arguments are skipped in a1, a2, a3 order.
	always_comb begin
		state_next = state;
		if (expired) begin
			state_next = IDLE;  // Abandon without commit.
		end else begin
			case (state)
				IDLE: if (accept) state_next = ARG;
				ARG: begin
					if (arg_mask[0])      state_next = A1;
					else if (arg_mask[1]) state_next = A2H;
					else if (arg_mask[2]) state_next = A3H;
					else                  state_next = DONE;
				end
				A1: if (accept) begin
					if (arg_mask[1])      state_next = A2H;
					else if (arg_mask[2]) state_next = A3H;
					else                  state_next = DONE;
				end
				A2H: if (accept) state_next = A2L;
				A2L: if (accept) state_next = arg_mask[2] ? A3H : DONE;
				A3H: if (accept) state_next = A3L;
				A3L: if (accept) state_next = DONE;
				default: state_next = IDLE;  // DONE commits and returns.
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state   <= IDLE;
			ready   <= 1'b0;
			timeout <= 1'b0;
		end else begin
			state   <= state_next;
			ready   <= commit;   // Lines up with the output registers.
			timeout <= expired;
		end
	end

endmodule

`default_nettype wire

/* design/msg_rx_pkg.sv */
`default_nettype none

package msg_rx_pkg;

	////////////////////
	// Link field types
	////////////////////

	// Bit 0 is the MSB throughout the link.
	typedef logic [0:7] msg_byte_t;
	typedef logic [0:15] msg_word_t;    // High byte is [0:7].
	typedef logic [0:4] msg_opcode_t;   // Command byte bits 0 to 4.
	typedef logic [0:2] msg_argmask_t;  // Bit 0 a1, bit 1 a2, bit 2 a3.
	typedef logic [2:0] msg_field_t;
	typedef logic [4:0] msg_tmr_t;

	// Staging field selects.
	localparam msg_field_t FIELD_CMD = 3'd0;
	localparam msg_field_t FIELD_A1  = 3'd1;
	localparam msg_field_t FIELD_A2H = 3'd2;
	localparam msg_field_t FIELD_A2L = 3'd3;
	localparam msg_field_t FIELD_A3H = 3'd4;
	localparam msg_field_t FIELD_A3L = 3'd5;

	////////////////////
	// Commands
	////////////////////

	localparam msg_opcode_t OP_R   = 5'd1;
	localparam msg_opcode_t OP_W   = 5'd2;
	localparam msg_opcode_t OP_IN  = 5'd3;
	localparam msg_opcode_t OP_PA  = 5'd4;
	localparam msg_opcode_t OP_OK  = 5'd5;
	localparam msg_opcode_t OP_PE  = 5'd6;
	localparam msg_opcode_t OP_EN  = 5'd7;
	localparam msg_opcode_t OP_CPD = 5'd8;
	localparam msg_opcode_t OP_CPR = 5'd9;
	localparam msg_opcode_t OP_CPF = 5'd10;
	localparam msg_opcode_t OP_CPS = 5'd11;

	// One-hot flags, unknown covers every unmapped opcode.
	typedef struct packed {
		logic r;
		logic w;
		logic in;
		logic pa;
		logic ok;
		logic pe;
		logic en;
		logic cpd;
		logic cpr;
		logic cpf;
		logic cps;
		logic unknown;
	} msg_cmd_t;

	typedef struct packed {
		msg_byte_t a1;
		msg_word_t a2;
		msg_word_t a3;
	} msg_args_t;

	// Idle cycles allowed between bytes inside a message.
	localparam msg_tmr_t MSG_TIMEOUT = 5'd16;

endpackage

`default_nettype wire

/* dv/msg_rx_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_rx_assertions (
	input logic                  clk_sys,
	input logic                  rst,
	input msg_rx_pkg::msg_cmd_t  cmd,
	input msg_rx_pkg::msg_args_t args,
	input logic                  ready,
	input logic                  timeout
);

	int unsigned fail_count = 0;

	task automatic note_failure(input string what);
		fail_count++;
		$error("%s", what);
	endtask

	////////////////////
	// Pulses
	////////////////////

	assert property (@(posedge clk_sys) disable iff (rst) !(ready && timeout))
		else note_failure("ready and timeout high in the same cycle");
	assert property (@(posedge clk_sys) disable iff (rst) ready |=> !ready)
		else note_failure("ready held for more than one cycle");
	assert property (@(posedge clk_sys) disable iff (rst) timeout |=> !timeout)
		else note_failure("timeout held for more than one cycle");

	////////////////////
	// Published values
	////////////////////

	// Outputs move only on the commit edge, which ready follows.
	assert property (@(posedge clk_sys) disable iff (rst)
		(!ready && !$past(rst)) |-> ($stable(cmd) && $stable(args)))
		else note_failure("cmd or args changed outside a ready cycle");
	assert property (@(posedge clk_sys) disable iff (rst) ready |-> $onehot(cmd))
		else note_failure("cmd does not hold exactly one flag after commit");

	// Quiet for two cycles once reset drops.
	assert property (@(posedge clk_sys)
		$fell(rst) |-> (!ready && !timeout && cmd == '0 && args == '0) [*2])
		else note_failure("outputs active right after reset");

endmodule

bind msg_rx msg_rx_assertions msg_rx_assertions_i (.*);

`default_nettype wire

/* dv/msg_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_rx_tb;

	import msg_rx_pkg::*;

	localparam int WAIT_LIMIT = 40;

	logic        clk_sys;
	logic        rst;
	msg_byte_t   byte_data;
	logic        byte_valid;
	msg_cmd_t    cmd;
	msg_args_t   args;
	logic        ready;
	logic        timeout;
	logic [15:0] lfsr = 16'd3;
	logic [11:0] exp_cmd = '0;   // Last committed message.
	logic [39:0] exp_args = '0;  // a1, a2, a3 with the high byte first.
	int          checks = 0;
	int          mismatches = 0;
	int          failures = 0;

	msg_rx msg_rx_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.cmd        (cmd),
		.args       (args),
		.ready      (ready),
		.timeout    (timeout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	////////////////////
	// Helpers
	////////////////////

	// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1 and one step per bit.
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v    = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// Flags run from r down to unknown, so opcode 1 is the top bit.
	function automatic logic [11:0] expected_flags(input logic [4:0] op);
		if (op >= 5'd1 && op <= 5'd11) begin
			return 12'h001 << (12 - int'(op));
		end
		return 12'h001;
	endfunction

	// Returns on the edge that samples the strobe.
	task automatic strobe(input logic [7:0] b, input int gap);
		repeat (gap) @(posedge clk_sys);
		@(posedge clk_sys);
		byte_valid <= 1'b1;
		byte_data  <= b;
		@(posedge clk_sys);
		byte_valid <= 1'b0;
	endtask

	task automatic check_outputs();
		checks++;
		assert (cmd === exp_cmd) else begin
			mismatches++;
			$display("Mismatch cmd: got %h expected %h", cmd, exp_cmd);
		end
		assert (args === exp_args) else begin
			mismatches++;
			$display("Mismatch args: got %h expected %h", args, exp_args);
		end
	endtask

	// Edges count from the edge that took the last byte.
	task automatic await_result(input logic want_ready, input int latency);
		int edges;
		edges = 0;
		@(negedge clk_sys);
		while (!ready && !timeout && edges < WAIT_LIMIT) begin
			@(negedge clk_sys);
			edges++;
		end
		if (!ready && !timeout) begin
			failures++;
			$display("No ready or timeout pulse within %0d cycles", WAIT_LIMIT);
		end else begin
			assert (ready == want_ready) else begin
				mismatches++;
				$display("Mismatch ready: got %h expected %h", ready, want_ready);
			end
			assert (edges == latency) else begin
				mismatches++;
				$display("Mismatch pulse latency: got %h expected %h", edges, latency);
			end
			check_outputs();
		end
	endtask

	task automatic send_message(input logic [4:0] op, input logic [2:0] mask,
		input logic stray);
		logic [15:0] a1;
		logic [15:0] a2;
		logic [15:0] a3;
		a1 = take_bits(8);
		a2 = take_bits(16);
		a3 = take_bits(16);
		strobe({op, mask}, 0);
		if (stray) begin
			byte_valid <= 1'b1;  // Held a second cycle so that it lands in ARG.
			byte_data  <= ~a1[7:0];
			@(posedge clk_sys);
			byte_valid <= 1'b0;
		end
		if (mask[2]) begin
			strobe(a1[7:0], take_bits(3));
			exp_args[39:32] = a1[7:0];
		end
		if (mask[1]) begin
			strobe(a2[15:8], take_bits(3));
			strobe(a2[7:0], take_bits(3));
			exp_args[31:16] = a2;
		end
		if (mask[0]) begin
			strobe(a3[15:8], take_bits(3));
			strobe(a3[7:0], take_bits(3));
			exp_args[15:0] = a3;
		end
		exp_cmd = expected_flags(op);
		// Command edge plus two or last argument edge plus one.
		await_result(1'b1, (mask == 3'b000) ? 2 : 1);
	endtask

	////////////////////
	// Sequence
	////////////////////

	initial begin
		logic [15:0] r;
		rst        = 1'b1;
		byte_valid = 1'b0;
		byte_data  = '0;
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		for (int op = 0; op < 32; op++) begin
			send_message(op[4:0], 3'b000, 1'b0);
		end
		// Each mask twice so that absent arguments show the older values.
		for (int n = 0; n < 16; n++) begin
			r = take_bits(5);
			send_message(r[4:0], n[2:0], 1'b0);
		end
		send_message(5'd2, 3'b111, 1'b1);
		// Stall after the a2 high byte.
		strobe({5'd1, 3'b010}, 0);
		strobe(8'h5a, 0);
		await_result(1'b0, MSG_TIMEOUT + 1);
		// No a2 here, so a2 keeps its value from before the stall.
		send_message(5'd3, 3'b101, 1'b0);
		// Reset partway through a message.
		strobe({5'd4, 3'b111}, 0);
		strobe(8'hc3, 0);
		@(posedge clk_sys);
		rst <= 1'b1;
		repeat (4) @(posedge clk_sys);
		rst <= 1'b0;
		@(negedge clk_sys);
		exp_cmd  = '0;
		exp_args = '0;
		check_outputs();
		send_message(5'd5, 3'b100, 1'b0);
		$display("Checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
			checks, mismatches, failures, msg_rx_i.msg_rx_assertions_i.fail_count);
		if (mismatches + failures + msg_rx_i.msg_rx_assertions_i.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* msg_rx.f */
design/msg_rx_pkg.sv
design/msg_cmd_dec.sv
design/msg_arg_collect.sv
design/msg_byte_timer.sv
design/msg_rx_ctrl.sv
design/msg_rx.sv
dv/msg_rx_assertions.sv
dv/msg_rx_tb.sv
